/* Makefile */
TOP       ?= aluCoreTb
FILELIST  ?= list.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "Variables: TOP FILELIST BUILD LOG VERILATOR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG) || (echo "No pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

/* design/aluCore.sv */
`timescale 1ns/1ps
`default_nettype none
`include "z80Alu_defines.svh"

module aluCore
  import z80AluPkg::*;
(
  input  logic       clk,
  input  logic       rstN,
  input  logic       opValid,
  input  logic       opPrefixCb,
  input  logic [7:0] opCode,
  input  logic [7:0] opImm,
  input  logic       hold,
  output logic       opReady,
  output logic       opIllegal,
  output logic       resValid,
  output logic [7:0] result,
  output logic [7:0] acc,
  output logic [7:0] flags
);

  aluCmdT cmd;
  aluCmdT head;
  logic   push;
  logic   pop;
  logic   notEmpty;

  opDecoder i_opDecoder (
    .clk(clk),
    .rstN(rstN),
    .opValid(opValid),
    .opPrefixCb(opPrefixCb),
    .opCode(opCode),
    .opImm(opImm),
    .push(push),
    .cmd(cmd),
    .opIllegal(opIllegal)
  );

  cmdQueue #(
    .payloadT(aluCmdT),
    .DEPTH(`ALU_QUEUE_DEPTH)
  ) i_cmdQueue (
    .clk(clk),
    .rstN(rstN),
    .push(push),
    .din(cmd),
    .pop(pop),
    .head(head),
    .notEmpty(notEmpty),
    .opReady(opReady)
  );

  aluExecute #(
    .MODE(`ALU_MODE)
  ) i_aluExecute (
    .clk(clk),
    .rstN(rstN),
    .head(head),
    .notEmpty(notEmpty),
    .hold(hold),
    .pop(pop),
    .resValid(resValid),
    .result(result),
    .acc(acc),
    .flags(flags)
  );

endmodule

`default_nettype wire

/* design/aluExecute.sv */
`timescale 1ns/1ps
`default_nettype none

module aluExecute
  import z80AluPkg::*;
#(
  parameter int MODE = 0
) (
  input  logic       clk,
  input  logic       rstN,
  input  aluCmdT     head,
  input  logic       notEmpty,
  input  logic       hold,
  output logic       pop,
  output logic       resValid,
  output logic [7:0] result,
  output logic [7:0] acc,
  output logic [7:0] flags
);

  logic [7:0] busB;
  logic [7:0] aluQ;
  logic [7:0] aluF;
  logic       bitOp;

  assign pop   = notEmpty & ~hold;
  assign bitOp = head.aluOp inside {ALU_BIT, ALU_SET, ALU_RES};
  assign busB  = bitOp ? acc : head.operandB;  // Bit ops work on A itself

  z80Alu #(
    .MODE(MODE)
  ) i_z80Alu (
    .aluOp(head.aluOp),
    .ir(head.ir),
    .iSet(head.iSet),
    .busA(acc),
    .busB(busB),
    .fIn(flags),
    .q(aluQ),
    .fOut(aluF)
  );

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      resValid <= 1'b0;
      acc      <= 8'h00;
      flags    <= 8'h00;
    end
    else
    begin
      resValid <= pop;
      if (pop)
      begin
        flags <= aluF;  // SET and RES pass F through
        if (head.writesAcc)
          acc <= aluQ;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (pop)
      result <= aluQ;
  end

  // Only CP and BIT may leave A unchanged
  flagsOnly: assert property (@(posedge clk) disable iff (!rstN)
    pop && !head.writesAcc |-> head.aluOp inside {ALU_CP, ALU_BIT});

endmodule

`default_nettype wire

/* design/cmdQueue.sv */
`timescale 1ns/1ps
`default_nettype none

module cmdQueue #(
  parameter type payloadT = logic [7:0],
  parameter int  DEPTH    = 4
) (
  input  logic    clk,
  input  logic    rstN,
  input  logic    push,
  input  payloadT din,
  input  logic    pop,
  output payloadT head,
  output logic    notEmpty,
  output logic    opReady
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payloadT            mem [DEPTH];
  logic [PTR_W-1:0]   wrPtr;
  logic [PTR_W-1:0]   rdPtr;
  logic [CNT_W-1:0]   count;

  assign head     = mem[rdPtr];  // Show-ahead
  assign notEmpty = (count != '0);
  // One slot kept back for the command sitting in the decoder register
  assign opReady  = (count < CNT_W'(DEPTH - 1));

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (push)
        wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
      if (pop)
        rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wrPtr] <= din;
  end

  noOverflow: assert property (@(posedge clk) disable iff (!rstN)
    push |-> count != CNT_W'(DEPTH));
  noUnderflow: assert property (@(posedge clk) disable iff (!rstN)
    pop |-> count != '0);

endmodule

`default_nettype wire

/* design/opDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module opDecoder
  import z80AluPkg::*;
(
  input  logic       clk,
  input  logic       rstN,
  input  logic       opValid,
  input  logic       opPrefixCb,
  input  logic [7:0] opCode,
  input  logic [7:0] opImm,
  output logic       push,
  output aluCmdT     cmd,
  output logic       opIllegal
);

  aluCmdT decCmd;
  logic   decLegal;

  always_comb
  begin
    decCmd.aluOp     = ALU_ADD;
    decCmd.ir        = opCode[5:0];
    decCmd.iSet      = 2'd0;
    decCmd.operandB  = 8'h00;
    decCmd.writesAcc = 1'b1;
    decLegal         = 1'b0;
    if (!opPrefixCb)
    begin
      if (opCode[7:6] == 2'b11 && opCode[2:0] == 3'b110)
      begin
        decLegal          = 1'b1;  // ALU op with n
        decCmd.aluOp      = aluOpT'({1'b0, opCode[5:3]});
        decCmd.operandB   = opImm;
        decCmd.writesAcc  = (opCode[5:3] != 3'b111);  // CP leaves A alone
      end
      else if (opCode == 8'h27)
      begin
        decLegal     = 1'b1;
        decCmd.aluOp = ALU_DAA;
      end
    end
    else if (opCode[2:0] == 3'd7)
    begin
      // Only register A is supported after the CB prefix
      decLegal    = 1'b1;
      decCmd.iSet = 2'd1;
      case (opCode[7:6])
        2'b00:   decCmd.aluOp = ALU_ROT;
        2'b01:   decCmd.aluOp = ALU_BIT;
        2'b10:   decCmd.aluOp = ALU_RES;
        default: decCmd.aluOp = ALU_SET;
      endcase
      decCmd.writesAcc = (opCode[7:6] != 2'b01);  // BIT only tests
    end
  end

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      push      <= 1'b0;
      opIllegal <= 1'b0;
    end
    else
    begin
      push      <= opValid & decLegal;
      opIllegal <= opValid & ~decLegal;
    end
  end

  always_ff @(posedge clk)
  begin
    if (opValid)
      cmd <= decCmd;
  end

endmodule

`default_nettype wire

/* design/z80Alu.sv */
`timescale 1ns/1ps
`default_nettype none
`include "z80Alu_defines.svh"

module z80Alu
  import z80AluPkg::*;
#(
  parameter int MODE = 0
) (
  input  aluOpT      aluOp,
  input  logic [5:0] ir,
  input  logic [1:0] iSet,
  input  logic [7:0] busA,
  input  logic [7:0] busB,
  input  logic [7:0] fIn,
  output logic [7:0] q,
  output logic [7:0] fOut
);

  logic [7:0] bEff;
  logic [7:0] sumV;
  logic [7:0] bitMask;
  logic [4:0] loSum;
  logic [3:0] midSum;
  logic [1:0] hiSum;
  logic       carryIn;
  logic       overflow;
  logic [8:0] daaQ;

  assign bitMask = 8'h01 << ir[5:3];
  assign bEff    = aluOp[1] ? ~busB : busB;  // Subtract by inverted add
  // ADC and SBC chain in the carry, SUB and CP force it
  assign carryIn = aluOp[1] ^ (~aluOp[2] & aluOp[0] & fIn[`FLAG_C]);

  // Split adder exposes half carry and carry into bit 7
  assign loSum    = {1'b0, busA[3:0]} + {1'b0, bEff[3:0]} + {4'd0, carryIn};
  assign midSum   = {1'b0, busA[6:4]} + {1'b0, bEff[6:4]} + {3'd0, loSum[4]};
  assign hiSum    = {1'b0, busA[7]} + {1'b0, bEff[7]} + {1'b0, midSum[3]};
  assign sumV     = {hiSum[0], midSum[2:0], loSum[3:0]};
  assign overflow = hiSum[1] ^ midSum[3];

  always_comb
  begin
    q    = busA;
    fOut = fIn;
    daaQ = {1'b0, busA};
    case (aluOp)
      ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC, ALU_AND, ALU_XOR, ALU_OR, ALU_CP:
      begin
        fOut[`FLAG_N] = 1'b0;
        fOut[`FLAG_C] = 1'b0;
        case (aluOp[2:0])
          3'b000, 3'b001:
          begin
            q             = sumV;
            fOut[`FLAG_C] = hiSum[1];
            fOut[`FLAG_H] = loSum[4];
            fOut[`FLAG_P] = overflow;
          end
          3'b010, 3'b011, 3'b111:
          begin
            q             = sumV;
            fOut[`FLAG_N] = 1'b1;
            fOut[`FLAG_C] = ~hiSum[1];  // Borrow
            fOut[`FLAG_H] = ~loSum[4];
            fOut[`FLAG_P] = overflow;
          end
          3'b100:
          begin
            q             = busA & busB;
            fOut[`FLAG_H] = 1'b1;
            fOut[`FLAG_P] = ~^q;
          end
          3'b101:
          begin
            q             = busA ^ busB;
            fOut[`FLAG_H] = 1'b0;
            fOut[`FLAG_P] = ~^q;
          end
          default:
          begin
            q             = busA | busB;
            fOut[`FLAG_H] = 1'b0;
            fOut[`FLAG_P] = ~^q;
          end
        endcase
        // CP copies X and Y from the operand, not the difference
        fOut[`FLAG_X] = (aluOp == ALU_CP) ? busB[3] : q[3];
        fOut[`FLAG_Y] = (aluOp == ALU_CP) ? busB[5] : q[5];
        fOut[`FLAG_Z] = (q == 8'h00);
        fOut[`FLAG_S] = q[7];
      end
      ALU_DAA:
      begin
        if (!fIn[`FLAG_N])
        begin
          if (daaQ[3:0] > 4'd9 || fIn[`FLAG_H])
          begin
            fOut[`FLAG_H] = (daaQ[3:0] > 4'd9);
            daaQ          = daaQ + 9'd6;
          end
          if (daaQ[8:4] > 5'd9 || fIn[`FLAG_C])
            daaQ = daaQ + 9'h060;
        end
        else
        begin
          if (daaQ[3:0] > 4'd9 || fIn[`FLAG_H])
          begin
            if (daaQ[3:0] > 4'd5)
              fOut[`FLAG_H] = 1'b0;
            daaQ[7:0] = daaQ[7:0] - 8'd6;
          end
          if (busA > 8'd153 || fIn[`FLAG_C])
            daaQ = daaQ - 9'h160;
        end
        q             = daaQ[7:0];
        fOut[`FLAG_C] = fIn[`FLAG_C] | daaQ[8];  // Carry is sticky
        fOut[`FLAG_X] = q[3];
        fOut[`FLAG_Y] = q[5];
        fOut[`FLAG_Z] = (q == 8'h00);
        fOut[`FLAG_S] = q[7];
        fOut[`FLAG_P] = ~^q;
      end
      ALU_BIT:
      begin
        q             = busB & bitMask;
        fOut[`FLAG_S] = q[7];
        fOut[`FLAG_Z] = (q == 8'h00);
        fOut[`FLAG_P] = (q == 8'h00);
        fOut[`FLAG_H] = 1'b1;
        fOut[`FLAG_N] = 1'b0;
        // (HL) form would take X and Y from elsewhere
        fOut[`FLAG_X] = (ir[2:0] != 3'b110) & busB[3];
        fOut[`FLAG_Y] = (ir[2:0] != 3'b110) & busB[5];
      end
      ALU_SET: q = busB | bitMask;
      ALU_RES: q = busB & ~bitMask;
      ALU_ROT:
      begin
        case (ir[5:3])
          3'b000:  q = {busA[6:0], busA[7]};        // RLC
          3'b001:  q = {busA[0], busA[7:1]};        // RRC
          3'b010:  q = {busA[6:0], fIn[`FLAG_C]};   // RL
          3'b011:  q = {fIn[`FLAG_C], busA[7:1]};   // RR
          3'b100:  q = {busA[6:0], 1'b0};           // SLA
          3'b101:  q = {busA[7], busA[7:1]};        // SRA
          3'b110:  q = (MODE == 3) ? {busA[3:0], busA[7:4]} : {busA[6:0], 1'b1};
          default: q = {1'b0, busA[7:1]};           // SRL
        endcase
        fOut[`FLAG_C] = ir[3] ? busA[0] : busA[7];  // Bit shifted out
        if (MODE == 3 && ir[5:3] == 3'b110)
          fOut[`FLAG_C] = 1'b0;                     // SWAP
        fOut[`FLAG_H] = 1'b0;
        fOut[`FLAG_N] = 1'b0;
        fOut[`FLAG_X] = q[3];
        fOut[`FLAG_Y] = q[5];
        fOut[`FLAG_S] = q[7];
        fOut[`FLAG_Z] = (q == 8'h00);
        fOut[`FLAG_P] = ~^q;
        if (iSet == 2'd0)
        begin
          // Accumulator rotates keep S, Z and P
          fOut[`FLAG_S] = fIn[`FLAG_S];
          fOut[`FLAG_Z] = fIn[`FLAG_Z];
          fOut[`FLAG_P] = fIn[`FLAG_P];
        end
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* design/z80AluPkg.sv */
`default_nettype none

package z80AluPkg;

  typedef enum logic [3:0] {
    ALU_ADD = 4'd0,
    ALU_ADC = 4'd1,
    ALU_SUB = 4'd2,
    ALU_SBC = 4'd3,
    ALU_AND = 4'd4,
    ALU_XOR = 4'd5,
    ALU_OR  = 4'd6,
    ALU_CP  = 4'd7,
    ALU_ROT = 4'd8,   // Rotate and shift group, selected by ir[5:3]
    ALU_BIT = 4'd9,
    ALU_SET = 4'd10,
    ALU_RES = 4'd11,
    ALU_DAA = 4'd12
  } aluOpT;

  typedef struct packed {
    aluOpT      aluOp;
    logic [5:0] ir;        // Bit or rotate select, then register field
    logic [1:0] iSet;      // 0 main set, 1 CB set
    logic [7:0] operandB;
    logic       writesAcc;
  } aluCmdT;

endpackage

`default_nettype wire

/* design/z80Alu_defines.svh */
`ifndef Z80ALU_DEFINES_SVH
`define Z80ALU_DEFINES_SVH

// Bit positions inside F
`define FLAG_C 3'd0
`define FLAG_N 3'd1
`define FLAG_P 3'd2
`define FLAG_X 3'd3
`define FLAG_H 3'd4
`define FLAG_Y 3'd5
`define FLAG_Z 3'd6
`define FLAG_S 3'd7

`define ALU_QUEUE_DEPTH 4  // Command queue entries

// 0 is the plain Z80, 3 replaces SLL with SWAP
`define ALU_MODE 0

`endif

/* list.f */
+incdir+design
+incdir+tests
design/z80AluPkg.sv
design/z80Alu.sv
design/opDecoder.sv
design/cmdQueue.sv
design/aluExecute.sv
design/aluCore.sv
tests/aluCoreTb.sv

/* tests/aluModel.svh */
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

`include "z80Alu_defines.svh"

// Results are packed as {result, new A, new F}

function automatic logic isLegal(input logic cb, input logic [7:0] code);
  if (cb)
    return code[2:0] == 3'd7;  // Register A only
  return (code[7:6] == 2'b11 && code[2:0] == 3'b110) || code == 8'h27;
endfunction

function automatic logic [7:0] setSzxyp(input logic [7:0] f, input logic [7:0] v);
  logic [7:0] r;
  r = f;
  r[`FLAG_S] = v[7];
  r[`FLAG_Z] = (v == 8'h00);
  r[`FLAG_Y] = v[5];
  r[`FLAG_X] = v[3];
  r[`FLAG_P] = ~^v;  // Even parity
  return r;
endfunction

function automatic logic [23:0] arithOp(input logic [2:0] op, input logic [7:0] a,
                                        input logic [7:0] b, input logic [7:0] f);
  logic [8:0] wide;
  logic [4:0] nib;
  logic [7:0] r;
  logic [7:0] fo;
  logic       cin;
  logic       ovf;
  cin  = op[0] & ~op[2] & f[`FLAG_C];  // ADC and SBC only
  fo   = 8'h00;
  wide = 9'h000;
  nib  = 5'h00;
  r    = 8'h00;
  ovf  = 1'b0;
  case (op)
    3'd0, 3'd1:
    begin
      wide = {1'b0, a} + {1'b0, b} + {8'd0, cin};
      nib  = {1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'd0, cin};
      r    = wide[7:0];
      ovf  = (a[7] == b[7]) && (r[7] != a[7]);  // Signed overflow
    end
    3'd2, 3'd3, 3'd7:
    begin
      wide = {1'b0, a} - {1'b0, b} - {8'd0, cin};
      nib  = {1'b0, a[3:0]} - {1'b0, b[3:0]} - {4'd0, cin};
      r    = wide[7:0];
      fo[`FLAG_N] = 1'b1;
      ovf  = (a[7] != b[7]) && (r[7] != a[7]);
    end
    3'd4:
    begin
      r = a & b;
      fo[`FLAG_H] = 1'b1;
    end
    3'd5: r = a ^ b;
    default: r = a | b;
  endcase
  if (op[2] == 1'b0 || op == 3'd7)
  begin
    fo[`FLAG_C] = wide[8];  // Carry or borrow
    fo[`FLAG_H] = nib[4];
  end
  fo = setSzxyp(fo, r);
  if (op[2] == 1'b0 || op == 3'd7)
    fo[`FLAG_P] = ovf;  // Arithmetic reports overflow, logic keeps parity
  if (op == 3'd7)
  begin
    fo[`FLAG_X] = b[3];
    fo[`FLAG_Y] = b[5];
    return {r, a, fo};
  end
  return {r, r, fo};
endfunction

function automatic logic [23:0] daaOp(input logic [7:0] a, input logic [7:0] f);
  logic [7:0] corr;
  logic [7:0] r;
  logic [7:0] fo;
  logic       c;
  corr = 8'h00;
  c    = f[`FLAG_C];
  fo   = f;
  if (f[`FLAG_H] || a[3:0] > 4'd9)
    corr = corr | 8'h06;
  if (f[`FLAG_C] || a > 8'h99)
  begin
    corr = corr | 8'h60;
    c    = 1'b1;
  end
  if (f[`FLAG_N])
  begin
    r = a - corr;
    fo[`FLAG_H] = f[`FLAG_H] && (a[3:0] < 4'd6);
  end
  else
  begin
    r = a + corr;
    fo[`FLAG_H] = (a[3:0] > 4'd9);
  end
  fo = setSzxyp(fo, r);
  fo[`FLAG_C] = c;
  return {r, r, fo};
endfunction

function automatic logic [23:0] cbOp(input logic [7:0] code, input logic [7:0] a,
                                     input logic [7:0] f);
  logic [2:0] sel;
  logic [7:0] r;
  logic [7:0] fo;
  logic       out;
  sel = code[5:3];
  fo  = f;
  r   = a;
  out = 1'b0;
  case (code[7:6])
    2'b00:
    begin
      case (sel)
        3'd0: {out, r} = {a[7], a[6:0], a[7]};  // RLC
        3'd1: {out, r} = {a[0], a[0], a[7:1]};  // RRC
        3'd2: {out, r} = {a[7], a[6:0], f[`FLAG_C]};
        3'd3: {out, r} = {a[0], f[`FLAG_C], a[7:1]};
        3'd4: {out, r} = {a[7], a[6:0], 1'b0};
        3'd5: {out, r} = {a[0], a[7], a[7:1]};
        3'd6:
        begin
          if (`ALU_MODE == 3)
            {out, r} = {1'b0, a[3:0], a[7:4]};  // SWAP
          else
            {out, r} = {a[7], a[6:0], 1'b1};  // SLL
        end
        default: {out, r} = {a[0], 1'b0, a[7:1]};
      endcase
      fo = setSzxyp(f, r);
      fo[`FLAG_C] = out;
      fo[`FLAG_H] = 1'b0;
      fo[`FLAG_N] = 1'b0;
      return {r, r, fo};
    end
    2'b01:
    begin
      r = a & (8'h01 << sel);
      fo[`FLAG_Z] = ~a[sel];
      fo[`FLAG_P] = ~a[sel];
      fo[`FLAG_S] = (sel == 3'd7) & a[7];
      fo[`FLAG_H] = 1'b1;
      fo[`FLAG_N] = 1'b0;
      fo[`FLAG_X] = a[3];
      fo[`FLAG_Y] = a[5];
      return {r, a, fo};  // BIT only tests
    end
    2'b10:
    begin
      r = a & ~(8'h01 << sel);
      return {r, r, f};
    end
    default:
    begin
      r = a | (8'h01 << sel);
      return {r, r, f};
    end
  endcase
endfunction

function automatic logic [23:0] evalOp(input logic cb, input logic [7:0] code,
                                       input logic [7:0] imm, input logic [7:0] a,
                                       input logic [7:0] f);
  if (cb)
    return cbOp(code, a, f);
  if (code == 8'h27)
    return daaOp(a, f);
  return arithOp(code[5:3], a, imm, f);
endfunction

`endif

/* tests/aluCoreTb.sv */
`timescale 1ns/1ps
`default_nettype none

module aluCoreTb;

  `include "aluModel.svh"

  localparam int NUM_IMM     = 60;
  localparam int NUM_DAA     = 30;  // Four ops per case
  localparam int NUM_CB      = 40;  // Two ops per case
  localparam int NUM_ILLEGAL = 20;
  localparam int NUM_BURST   = 6;   // Three ops per burst
  localparam int TOTAL_OPS   = NUM_IMM + 4 * NUM_DAA + 2 * NUM_CB + NUM_ILLEGAL
                               + 3 * NUM_BURST + 1;
  localparam int TIMEOUT_CYCLES = TOTAL_OPS * 3 + 400;  // Margin for reset, holds, drains

  logic       clk;
  logic       rstN;
  logic       opValid;
  logic       opPrefixCb;
  logic [7:0] opCode;
  logic [7:0] opImm;
  logic       hold;
  logic       opReady;
  logic       opIllegal;
  logic       resValid;
  logic [7:0] result;
  logic [7:0] acc;
  logic [7:0] flags;

  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  int          lastStrobeCycle = 0;
  int          lastResCycle = 0;
  logic [7:0]  mA = 8'h00;  // Model accumulator
  logic [7:0]  mF = 8'h00;
  logic [23:0] expQ [$];    // {result, acc, flags} in op order

  aluCore i_aluCore (
    .clk(clk),
    .rstN(rstN),
    .opValid(opValid),
    .opPrefixCb(opPrefixCb),
    .opCode(opCode),
    .opImm(opImm),
    .hold(hold),
    .opReady(opReady),
    .opIllegal(opIllegal),
    .resValid(resValid),
    .result(result),
    .acc(acc),
    .flags(flags)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk)
    cycles <= cycles + 1;

  always @(posedge clk)
  begin
    if (cycles >= TIMEOUT_CYCLES)
    begin
      errors++;
      $display("Timeout after %0d cycles, %0d results still outstanding",
               cycles, expQ.size());
      $display("Checks: %0d, errors: %0d", checks, errors);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  task automatic checkByte(input string name, input logic [7:0] got, input logic [7:0] want);
    checks++;
    assert (got === want)
    else
    begin
      errors++;
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, want);
    end
  endtask

  task automatic checkBit(input string name, input logic got, input logic want);
    checks++;
    assert (got === want)
    else
    begin
      errors++;
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, want);
    end
  endtask

  // Result monitor, every strobe must match the oldest expectation
  always @(posedge clk)
  begin
    logic [23:0] want;
    if (rstN && resValid)
    begin
      lastResCycle = cycles;
      if (expQ.size() == 0)
      begin
        errors++;
        $display("Result strobe seen with no operation outstanding");
      end
      else
      begin
        want = expQ.pop_front();
        checkByte("result", result, want[23:16]);
        checkByte("acc", acc, want[15:8]);
        checkByte("flags", flags, want[7:0]);
      end
    end
  end

  // One strobe, then two idle cycles so opReady is current at the next strobe
  task automatic sendOp(input logic cb, input logic [7:0] code, input logic [7:0] imm);
    logic [23:0] out;
    logic        legal;
    legal = isLegal(cb, code);
    @(posedge clk);
    while (!opReady)
      @(posedge clk);
    opValid    <= 1'b1;
    opPrefixCb <= cb;
    opCode     <= code;
    opImm      <= imm;
    lastStrobeCycle = cycles + 1;  // Edge that samples the strobe
    if (legal)
    begin
      out = evalOp(cb, code, imm, mA, mF);
      mA  = out[15:8];
      mF  = out[7:0];
      expQ.push_back(out);
    end
    @(posedge clk);
    opValid <= 1'b0;
    @(posedge clk);
    checkBit("opIllegal", opIllegal, !legal);
  endtask

  task automatic drain();
    while (expQ.size() != 0)
      @(posedge clk);
    repeat (2) @(posedge clk);
  endtask

  initial
  begin
    int          i;
    logic [31:0] r;
    logic [7:0]  x;
    logic [7:0]  y;
    logic [7:0]  code;
    logic        cb;
    rstN       = 1'b0;
    opValid    = 1'b0;
    opPrefixCb = 1'b0;
    opCode     = 8'h00;
    opImm      = 8'h00;
    hold       = 1'b0;
    void'($urandom(32'h2377_9b37));
    repeat (8) @(posedge clk);
    rstN <= 1'b1;
    @(posedge clk);
    checkByte("acc", acc, 8'h00);
    checkByte("flags", flags, 8'h00);
    checkBit("resValid", resValid, 1'b0);
    checkBit("opIllegal", opIllegal, 1'b0);
    checkBit("opReady", opReady, 1'b1);

    for (i = 0; i < NUM_IMM; i++)
    begin
      r = $urandom;
      sendOp(1'b0, {2'b11, r[2:0], 3'b110}, r[15:8]);
    end

    for (i = 0; i < NUM_DAA; i++)
    begin
      r = $urandom;
      x = {r[3:0] % 4'd10, r[7:4] % 4'd10};
      y = {r[11:8] % 4'd10, r[15:12] % 4'd10};
      sendOp(1'b0, 8'hE6, 8'h00);  // AND 0 clears A
      sendOp(1'b0, 8'hF6, x);
      sendOp(1'b0, r[16] ? 8'hD6 : 8'hC6, y);
      sendOp(1'b0, 8'h27, 8'h00);
    end

    for (i = 0; i < NUM_CB; i++)
    begin
      r = $urandom;
      sendOp(1'b0, r[16] ? 8'hC6 : 8'hEE, r[7:0]);  // ADD may leave a carry
      sendOp(1'b1, {r[15:11], 3'b111}, 8'h00);
    end

    for (i = 0; i < NUM_ILLEGAL; i++)
    begin
      do
      begin
        r    = $urandom;
        cb   = r[8];
        code = r[7:0];
      end
      while (isLegal(cb, code));
      sendOp(cb, code, r[23:16]);
    end

    for (i = 0; i < NUM_BURST; i++)
    begin
      drain();
      hold <= 1'b1;
      repeat (3)
      begin
        r = $urandom;
        sendOp(1'b0, {2'b11, r[2:0], 3'b110}, r[15:8]);
      end
      repeat (2) @(posedge clk);
      checkBit("opReady", opReady, 1'b0);
      r = $urandom;
      repeat (r[2:0] % 3'd6 + 3'd1) @(posedge clk);
      hold <= 1'b0;
    end

    // Isolated op through an empty pipeline
    drain();
    r = $urandom;
    sendOp(1'b0, 8'hC6, r[7:0]);
    drain();
    checks++;
    assert (lastResCycle - lastStrobeCycle == 3)
    else
    begin
      errors++;
      $display("Isolated op took %0d cycles from strobe to result instead of 3",
               lastResCycle - lastStrobeCycle);
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire
